// ==== design/riscv_pkg.sv ====
// Shared word, register index, opcode, ALU-control and selector types for the core

package riscv_pkg;

    // ------------------------------------------------------------------
    // Basic data types
    // ------------------------------------------------------------------
    typedef logic [31:0] word_t;      // PC, data, immediates, ALU values
    typedef logic [4:0]  reg_addr_t;  // Register index x0..x31

    // Reset vector used when the top level does not override it
    localparam word_t RESET_PC_DEFAULT = 32'h0000_0000;

    // ------------------------------------------------------------------
    // Opcodes of the supported subset
    // ------------------------------------------------------------------
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,  // lw
        OP_STORE  = 7'b0100011,  // sw
        OP_RTYPE  = 7'b0110011,  // add sub and or slt
        OP_BRANCH = 7'b1100011,  // beq
        OP_ITYPE  = 7'b0010011,  // addi andi ori slti
        OP_JAL    = 7'b1101111   // jal
    } opcode_t;

    // Immediate format select
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_src_t;

    // Writeback source select
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10   // Link value for jal
    } result_src_t;

    // Operation class from the main decoder
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,  // Address calculation
        ALUOP_SUB   = 2'b01,  // Branch compare
        ALUOP_FUNCT = 2'b10   // Look at funct3 / funct7
    } alu_op_t;

    // ALU operation
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_ctrl_t;

endpackage

// ==== design/control_unit.sv ====
// Main opcode decoder and ALU decoder driving all datapath selects and enables
`timescale 1ns/1ps

module control_unit (
    input  logic                     i_rst_n,      // Sync reset, active low
    input  logic [6:0]               i_opcode,     // Instruction bits 6:0
    input  logic [2:0]               i_funct3,     // Instruction bits 14:12
    input  logic                     i_funct7b5,   // Instruction bit 30
    input  logic                     i_zero,       // From ALU
    output logic                     o_reg_write,
    output riscv_pkg::imm_src_t      o_imm_src,
    output logic                     o_alu_src,    // 1 = immediate operand
    output riscv_pkg::result_src_t   o_result_src,
    output riscv_pkg::alu_ctrl_t     o_alu_ctrl,
    output logic                     o_dmem_we,
    output logic                     o_pc_src      // 1 = take PC + imm
);

    import riscv_pkg::*;

    logic [10:0] ctrl_vec;         // Packed control word
    logic        reg_write;
    logic [1:0]  imm_src_bits;
    logic        mem_write;
    logic [1:0]  result_src_bits;
    logic        branch;
    logic [1:0]  alu_op_bits;
    logic        jump;
    logic        is_rtype;

    // ------------------------------------------------------------------
    // Main decoder
    // Field order: reg_write imm_src alu_src mem_write result_src
    //              branch alu_op jump
    // ------------------------------------------------------------------
    always_comb begin
        case (opcode_t'(i_opcode))
            OP_LOAD:   ctrl_vec = {1'b1, IMM_I, 1'b1, 1'b0, RES_MEM, 1'b0, ALUOP_ADD, 1'b0};
            OP_STORE:  ctrl_vec = {1'b0, IMM_S, 1'b1, 1'b1, RES_ALU, 1'b0, ALUOP_ADD, 1'b0};
            OP_RTYPE:  ctrl_vec = {1'b1, IMM_I, 1'b0, 1'b0, RES_ALU, 1'b0, ALUOP_FUNCT, 1'b0};
            OP_BRANCH: ctrl_vec = {1'b0, IMM_B, 1'b0, 1'b0, RES_ALU, 1'b1, ALUOP_SUB, 1'b0};
            OP_ITYPE:  ctrl_vec = {1'b1, IMM_I, 1'b1, 1'b0, RES_ALU, 1'b0, ALUOP_FUNCT, 1'b0};
            OP_JAL:    ctrl_vec = {1'b1, IMM_J, 1'b0, 1'b0, RES_PC4, 1'b0, ALUOP_ADD, 1'b1};
            // Unknown opcode is a no-op, nothing written, PC + 4
            default:   ctrl_vec = {1'b0, IMM_I, 1'b0, 1'b0, RES_ALU, 1'b0, ALUOP_ADD, 1'b0};
        endcase
    end

    assign {reg_write, imm_src_bits, o_alu_src, mem_write,
            result_src_bits, branch, alu_op_bits, jump} = ctrl_vec;

    assign o_imm_src    = imm_src_t'(imm_src_bits);
    assign o_result_src = result_src_t'(result_src_bits);

    // ------------------------------------------------------------------
    // ALU decoder
    // ------------------------------------------------------------------
    assign is_rtype = (opcode_t'(i_opcode) == OP_RTYPE);  // addi never subtracts

    always_comb begin
        case (alu_op_t'(alu_op_bits))
            ALUOP_ADD: o_alu_ctrl = ALU_ADD;  // lw / sw address
            ALUOP_SUB: o_alu_ctrl = ALU_SUB;  // beq compare
            ALUOP_FUNCT: begin
                case (i_funct3)
                    3'b000:  o_alu_ctrl = (is_rtype && i_funct7b5) ? ALU_SUB : ALU_ADD;
                    3'b010:  o_alu_ctrl = ALU_SLT;
                    3'b110:  o_alu_ctrl = ALU_OR;
                    3'b111:  o_alu_ctrl = ALU_AND;
                    default: o_alu_ctrl = ALU_ADD;  // Unsupported funct3
                endcase
            end
            default:   o_alu_ctrl = ALU_ADD;
        endcase
    end

    // Branch taken only on equal compare, jal always redirects
    assign o_pc_src = (branch & i_zero) | jump;

    // No state changes while in reset
    assign o_reg_write = reg_write & i_rst_n;
    assign o_dmem_we   = mem_write & i_rst_n;

endmodule

// ==== design/alu.sv ====
// ALU with operand-B select, add/sub/and/or/slt and zero flag
`timescale 1ns/1ps

module alu (
    input  riscv_pkg::word_t     i_rs1_data,  // Operand A
    input  riscv_pkg::word_t     i_rs2_data,  // Register operand B
    input  riscv_pkg::word_t     i_imm,       // Immediate operand B
    input  logic                 i_alu_src,   // 1 = immediate
    input  riscv_pkg::alu_ctrl_t i_alu_ctrl,
    output riscv_pkg::word_t     o_result,
    output logic                 o_zero       // Result is zero, for beq
);

    import riscv_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t sum;
    word_t diff;
    logic  lt_signed;

    assign src_a = i_rs1_data;

    // Operand B mux
    assign src_b = i_alu_src ? i_imm : i_rs2_data;

    // ------------------------------------------------------------------
    // Arithmetic
    // ------------------------------------------------------------------
    assign sum  = src_a + src_b;
    assign diff = src_a - src_b;  // Also the beq compare

    // Signed compare for slt / slti
    assign lt_signed = $signed(src_a) < $signed(src_b);

    // ------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------
    always_comb begin
        case (i_alu_ctrl)
            ALU_ADD: o_result = sum;
            ALU_SUB: o_result = diff;
            ALU_AND: o_result = src_a & src_b;
            ALU_OR:  o_result = src_a | src_b;
            ALU_SLT: o_result = {31'b0, lt_signed};  // 0 or 1
            default: o_result = sum;
        endcase
    end

    // Zero flag
    assign o_zero = (o_result == '0);

endmodule

// ==== design/regfile.sv ====
// 32-entry register file with x0 tied to zero and writeback source mux
`timescale 1ns/1ps

module regfile (
    input  logic                     i_clk,
    input  logic                     i_rst_n,       // Sync reset, active low
    input  logic                     i_we,          // Write enable
    input  riscv_pkg::reg_addr_t     i_rs1,
    input  riscv_pkg::reg_addr_t     i_rs2,
    input  riscv_pkg::reg_addr_t     i_rd,
    input  riscv_pkg::result_src_t   i_result_src,  // Writeback source
    input  riscv_pkg::word_t         i_alu_result,
    input  riscv_pkg::word_t         i_mem_rdata,
    input  riscv_pkg::word_t         i_pc_plus4,    // jal link value
    output riscv_pkg::word_t         o_rs1_data,
    output riscv_pkg::word_t         o_rs2_data
);

    import riscv_pkg::*;

    word_t regs [32];   // x0..x31
    word_t wr_data;

    // Writeback mux
    always_comb begin
        case (i_result_src)
            RES_ALU: wr_data = i_alu_result;
            RES_MEM: wr_data = i_mem_rdata;   // lw
            RES_PC4: wr_data = i_pc_plus4;    // jal
            default: wr_data = i_alu_result;
        endcase
    end

    // ------------------------------------------------------------------
    // Write port, rising edge
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin  // x0 never written
            regs[i_rd] <= wr_data;
        end
    end

    // Combinational read ports, x0 reads zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== design/imm_extend.sv ====
// Immediate builder for I, S, B and J formats with sign extension
`timescale 1ns/1ps

module imm_extend (
    input  logic [31:7]          i_instr_hi,  // Instruction bits 31:7
    input  riscv_pkg::imm_src_t  i_imm_src,   // Format select
    output riscv_pkg::word_t     o_imm
);

    import riscv_pkg::*;

    logic sign;

    assign sign = i_instr_hi[31];  // Bit 31 is the sign in every format

    always_comb begin
        case (i_imm_src)
            // lw, addi, andi, ori, slti
            IMM_I: o_imm = {{20{sign}}, i_instr_hi[31:20]};
            // sw, split field
            IMM_S: o_imm = {{20{sign}}, i_instr_hi[31:25], i_instr_hi[11:7]};
            // beq, halfword offset
            IMM_B: o_imm = {{20{sign}}, i_instr_hi[7], i_instr_hi[30:25],
                            i_instr_hi[11:8], 1'b0};
            // jal, halfword offset
            IMM_J: o_imm = {{12{sign}}, i_instr_hi[19:12], i_instr_hi[20],
                            i_instr_hi[30:21], 1'b0};
            default: o_imm = {{20{sign}}, i_instr_hi[31:20]};
        endcase
    end

endmodule

// ==== design/pc_unit.sv ====
// Program counter register with PC+4, branch target and next-PC select
`timescale 1ns/1ps

module pc_unit #(
    parameter riscv_pkg::word_t RESET_PC = riscv_pkg::RESET_PC_DEFAULT  // Word aligned
) (
    input  logic              i_clk,
    input  logic              i_rst_n,     // Sync reset, active low
    input  logic              i_pc_src,    // 1 = jump to target
    input  riscv_pkg::word_t  i_imm,       // B or J offset
    output riscv_pkg::word_t  o_pc,
    output riscv_pkg::word_t  o_pc_plus4   // Also the jal link value
);

    import riscv_pkg::*;

    word_t pc_target;
    word_t pc_next;

    assign o_pc_plus4 = o_pc + 32'd4;
    assign pc_target  = o_pc + i_imm;       // PC-relative target

    // Next PC select
    assign pc_next = i_pc_src ? pc_target : o_pc_plus4;

    // PC register
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_pc <= RESET_PC;
        end else begin
            o_pc <= pc_next;  // One instruction per cycle
        end
    end

endmodule

// ==== design/riscv_core.sv ====
// Single-cycle RV32I subset core top level joining control and datapath
`timescale 1ns/1ps

module riscv_core #(
    parameter riscv_pkg::word_t RESET_PC = riscv_pkg::RESET_PC_DEFAULT
) (
    input  logic              i_clk,
    input  logic              i_rst_n,       // Sync reset, active low
    input  riscv_pkg::word_t  i_instr,       // Fetched word, same cycle
    input  riscv_pkg::word_t  i_dmem_rdata,  // Load data, same cycle
    output riscv_pkg::word_t  o_pc,
    output riscv_pkg::word_t  o_dmem_addr,   // ALU result, every instruction
    output riscv_pkg::word_t  o_dmem_wdata,
    output logic              o_dmem_we
);

    import riscv_pkg::*;

    // ------------------------------------------------------------------
    // Instruction fields
    // ------------------------------------------------------------------
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic [31:7] instr_hi;

    assign opcode   = i_instr[6:0];
    assign rd       = i_instr[11:7];
    assign funct3   = i_instr[14:12];
    assign rs1      = i_instr[19:15];
    assign rs2      = i_instr[24:20];
    assign funct7b5 = i_instr[30];     // sub vs add
    assign instr_hi = i_instr[31:7];   // Immediate bits

    // Control
    logic        reg_write;
    imm_src_t    imm_src;
    logic        alu_src;
    result_src_t result_src;
    alu_ctrl_t   alu_ctrl;
    logic        pc_src;
    logic        zero;

    // Datapath
    word_t       imm;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       alu_result;
    word_t       pc_plus4;

    // ------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------
    control_unit control_unit_inst (
        .i_rst_n      (i_rst_n),
        .i_opcode     (opcode),
        .i_funct3     (funct3),
        .i_funct7b5   (funct7b5),
        .i_zero       (zero),
        .o_reg_write  (reg_write),
        .o_imm_src    (imm_src),
        .o_alu_src    (alu_src),
        .o_result_src (result_src),
        .o_alu_ctrl   (alu_ctrl),
        .o_dmem_we    (o_dmem_we),
        .o_pc_src     (pc_src)
    );

    imm_extend imm_extend_inst (
        .i_instr_hi (instr_hi),
        .i_imm_src  (imm_src),
        .o_imm      (imm)
    );

    regfile regfile_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_we         (reg_write),
        .i_rs1        (rs1),
        .i_rs2        (rs2),
        .i_rd         (rd),
        .i_result_src (result_src),
        .i_alu_result (alu_result),
        .i_mem_rdata  (i_dmem_rdata),
        .i_pc_plus4   (pc_plus4),
        .o_rs1_data   (rs1_data),
        .o_rs2_data   (rs2_data)
    );

    alu alu_inst (
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_imm      (imm),
        .i_alu_src  (alu_src),
        .i_alu_ctrl (alu_ctrl),
        .o_result   (alu_result),
        .o_zero     (zero)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) pc_unit_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pc_src   (pc_src),
        .i_imm      (imm),
        .o_pc       (o_pc),
        .o_pc_plus4 (pc_plus4)
    );

    assign o_dmem_addr  = alu_result;
    assign o_dmem_wdata = rs2_data;  // sw data

endmodule

// ==== sim/tb_riscv_core.sv ====
// Testbench for riscv_core: clock, reset, random instructions, ISA and memory models, checks
`timescale 1ns/1ps

module tb_riscv_core;

    import riscv_pkg::*;

    localparam int    CLK_PERIOD     = 4;
    localparam int    RESET_CYCLES   = 8;
    localparam int    NUM_INSTR      = 2000;
    localparam int    TIMEOUT_CYCLES = NUM_INSTR + RESET_CYCLES + 92;  // 2100
    localparam word_t RESET_VEC      = 32'h0000_1000;  // Non-zero to exercise the parameter
    localparam word_t NOP_INSTR      = 32'h0000_0013;  // addi x0, x0, 0

    logic  i_clk;
    logic  i_rst_n;
    word_t i_instr;
    word_t i_dmem_rdata;
    word_t o_pc;
    word_t o_dmem_addr;
    word_t o_dmem_wdata;
    logic  o_dmem_we;

    integer seed;
    int     num_checks = 0;
    int     num_errors = 0;
    int     cycle_cnt  = 0;

    // ISA model state
    word_t model_regs [32];
    word_t model_pc;
    word_t model_mem [logic [29:0]];  // Keyed by address bits 31:2

    riscv_core #(
        .RESET_PC (RESET_VEC)
    ) riscv_core_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_instr      (i_instr),
        .i_dmem_rdata (i_dmem_rdata),
        .o_pc         (o_pc),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_we    (o_dmem_we)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Watchdog
    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Error: run timed out after %0d cycles", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("Fail %s: got %08h expected %08h (model pc %08h)", name, got, exp, model_pc);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("Fail %s: got %0h expected %0h (model pc %08h)", name, got, exp, model_pc);
        end
    endtask

    // Unwritten words read as zero
    function automatic word_t mem_read(input word_t addr);
        word_t data;
        if (model_mem.exists(addr[31:2])) data = model_mem[addr[31:2]];
        else data = '0;
        return data;
    endfunction

    // ------------------------------------------------------------------
    // Random instruction generator
    // ------------------------------------------------------------------
    function automatic reg_addr_t pick_reg();
        word_t r;
        r = $random(seed);
        return r[5] ? {2'b00, r[2:0]} : r[4:0];  // Bias to x0..x7 for reuse
    endfunction

    function automatic logic [2:0] pick_funct3(input logic [1:0] sel);
        case (sel)
            2'd0:    return 3'b000;  // add / addi
            2'd1:    return 3'b010;  // slt / slti
            2'd2:    return 3'b110;  // or / ori
            default: return 3'b111;  // and / andi
        endcase
    endfunction

    function automatic logic is_defined(input logic [6:0] op);
        case (op)
            OP_LOAD, OP_STORE, OP_RTYPE, OP_BRANCH, OP_ITYPE, OP_JAL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t gen_instr();
        word_t       r;
        word_t       instr;
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  op;
        logic [11:0] imm12;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        r    = $random(seed);
        kind = r[3:0];
        f3   = pick_funct3(r[5:4]);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        r    = $random(seed);  // Fresh bits for immediates
        imm12 = r[8] ? {4'b0000, r[5:0], 2'b00} : r[31:20];  // Small word region half the time
        if (r[8] && (kind inside {4'd6, 4'd7, 4'd8, 4'd9})) rs1 = '0;
        case (kind)
            4'd0, 4'd1, 4'd2: begin
                f7    = (f3 == 3'b000 && r[31]) ? 7'b0100000 : 7'b0000000;
                instr = {f7, rs2, rs1, f3, rd, OP_RTYPE};
            end
            4'd3, 4'd4, 4'd5, 4'd14, 4'd15: instr = {r[31:20], rs1, f3, rd, OP_ITYPE};
            4'd6, 4'd7:   instr = {imm12, rs1, 3'b010, rd, OP_LOAD};
            4'd8, 4'd9:   instr = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], OP_STORE};
            4'd10, 4'd11: instr = {r[31:25], rs2, rs1, 3'b000, r[11:7], OP_BRANCH};
            4'd12:        instr = {r[31:12], rd, OP_JAL};
            default: begin
                op = r[6:0];
                if (is_defined(op)) op = op ^ 7'b0000100;  // Flip bit 2, never a valid opcode
                instr = {r[31:7], op};
            end
        endcase
        return instr;
    endfunction

    // ------------------------------------------------------------------
    // ISA model
    // ------------------------------------------------------------------
    function automatic word_t alu_model(input logic [2:0] f3, input logic is_sub,
                                        input word_t a, input word_t b);
        case (f3)
            3'b000:  return is_sub ? (a - b) : (a + b);
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // One instruction: drive fetch, answer load, then check against the model
    task automatic step_instr();
        word_t      instr;
        logic [6:0] op;
        logic [2:0] f3;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      alu_exp;
        word_t      rd_val;
        word_t      next_pc;
        logic       rd_we;
        logic       st_exp;
        logic       addr_chk;
        instr   = gen_instr();
        i_instr = instr;
        #1;
        i_dmem_rdata = mem_read(o_dmem_addr);  // Memory answers the core's address
        #1;
        op       = instr[6:0];
        rd       = instr[11:7];
        f3       = instr[14:12];
        a        = model_regs[instr[19:15]];
        b        = model_regs[instr[24:20]];
        next_pc  = model_pc + 32'd4;
        alu_exp  = '0;
        rd_val   = '0;
        rd_we    = 1'b0;
        st_exp   = 1'b0;
        addr_chk = 1'b0;
        case (op)
            OP_RTYPE: begin
                alu_exp  = alu_model(f3, instr[30], a, b);
                rd_we    = 1'b1;
                rd_val   = alu_exp;
                addr_chk = 1'b1;
            end
            OP_ITYPE: begin
                alu_exp  = alu_model(f3, 1'b0, a, {{20{instr[31]}}, instr[31:20]});
                rd_we    = 1'b1;
                rd_val   = alu_exp;
                addr_chk = 1'b1;
            end
            OP_LOAD: begin
                alu_exp  = a + {{20{instr[31]}}, instr[31:20]};
                rd_we    = 1'b1;
                rd_val   = mem_read(alu_exp);
                addr_chk = 1'b1;
            end
            OP_STORE: begin
                alu_exp  = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                st_exp   = 1'b1;
                addr_chk = 1'b1;
            end
            OP_BRANCH: begin
                if (a == b) next_pc = model_pc + {{20{instr[31]}}, instr[7],
                                                  instr[30:25], instr[11:8], 1'b0};
            end
            OP_JAL: begin
                rd_we   = 1'b1;
                rd_val  = model_pc + 32'd4;  // Link
                next_pc = model_pc + {{12{instr[31]}}, instr[19:12], instr[20],
                                      instr[30:21], 1'b0};
            end
            default: ;  // Undefined opcode is a no-op
        endcase
        check_word("o_pc", o_pc, model_pc);
        check_bit("o_dmem_we", o_dmem_we, st_exp);
        if (addr_chk) check_word("o_dmem_addr", o_dmem_addr, alu_exp);
        if (st_exp) check_word("o_dmem_wdata", o_dmem_wdata, b);
        // State update, as at the next rising edge
        if (st_exp) model_mem[alu_exp[31:2]] = b;
        if (rd_we && (rd != '0)) model_regs[rd] = rd_val;  // x0 stays zero
        model_pc = next_pc;
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int n;
        seed         = 32'ha3f6_2e99;
        i_rst_n      = 1'b0;
        i_instr      = NOP_INSTR;
        i_dmem_rdata = '0;
        model_pc     = RESET_VEC;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // Reset, PC parked and no store
        repeat (RESET_CYCLES - 1) begin
            @(posedge i_clk);
            #3;
            check_word("o_pc", o_pc, RESET_VEC);
            check_bit("o_dmem_we", o_dmem_we, 1'b0);
        end
        @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        for (n = 0; n < NUM_INSTR; n++) begin
            if (n != 0) begin
                @(posedge i_clk);
                #1;
            end
            step_instr();
        end
        $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/riscv_pkg.sv
design/control_unit.sv
design/alu.sv
design/regfile.sv
design/imm_extend.sv
design/pc_unit.sv
design/riscv_core.sv
sim/tb_riscv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tb_riscv_core -o tb_riscv_core \
    && ./obj_dir/tb_riscv_core | tee /dev/stderr | grep -q "^sim passed$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
